// File: verification/router_stats_stim.txt
# W addr data exp_err | R addr exp_data exp_err (all hex)
# P dir(I/E) port count | E kind(F/B/D) port_mask repeats (all hex)
# Enable control and identity write
W 02 00000005 0
R 02 00000005 0
W 03 0000000A 0
R 03 0000000A 0
W 00 12345678 0
R 00 0100000A 0
# Ingress snapshot
P I 0 00001000
P I 1 00002001
P I 2 00003002
P I 3 00004003
E F F 1
E F E 1
E F C 1
E F 8 1
E B F 1
E B E 2
E B C 2
E B 8 2
W 04 00000000 0
W 04 0000000F 0
R 04 0000000F 0
R 06 00001000 0
R 07 00000001 0
R 08 00000001 0
R 09 00002001 0
R 0A 00000002 0
R 0B 00000003 0
R 0C 00003002 0
R 0D 00000003 0
R 0E 00000005 0
R 0F 00004003 0
R 10 00000004 0
R 11 00000007 0
W 04 00000000 0
W 04 0000000F 0
R 06 00001000 0
R 07 00000000 0
R 08 00000000 0
R 11 00000000 0
# Partial egress sampling
P E 0 00005000
P E 1 00006001
P E 2 00007002
P E 3 00008003
E D 5 2
E D 2 1
W 05 00000000 0
W 05 00000005 0
R 12 00005000 0
R 13 00000002 0
R 14 00000000 0
R 15 00000000 0
R 16 00007002 0
R 17 00000002 0
R 18 00000000 0
R 19 00000000 0
E D 2 3
W 05 00000000 0
W 05 00000002 0
R 14 00006001 0
R 15 00000004 0
R 12 00005000 0
R 13 00000002 0
# Out of range
R 1A 00000000 1
R 1F 00000000 1
R FF 00000000 1
W 1A 0000FFFF 1
W 40 0000FFFF 1
R 19 00000000 0

// File: all.f
+incdir+include
logic/router_regmap_pkg.sv
logic/router_port_pkg.sv
logic/ing_port_stats.sv
logic/egr_port_stats.sv
logic/router_reg_host.sv
logic/router_stats_top.sv
verification/router_stats_assert.sv
verification/router_stats_tb.sv

// File: Bender.yml
package:
  name: router_stats

sources:
  - include_dirs:
      - include
    files:
      - logic/router_regmap_pkg.sv
      - logic/router_port_pkg.sv
      - logic/ing_port_stats.sv
      - logic/egr_port_stats.sv
      - logic/router_reg_host.sv
      - logic/router_stats_top.sv
  - target: test
    files:
      - verification/router_stats_assert.sv
      - verification/router_stats_tb.sv

// File: verification/router_stats_tb.sv
////////////////////
// Testbench for the router statistics block
// Reset checks, stim-file commands and random reads
////////////////////

`timescale 1ns/1ps
`default_nettype none

module router_stats_tb
    import router_regmap_pkg::*, router_port_pkg::*;
;

    // Fixed words plus three per ingress port and two per egress port
    localparam int NUM_REGS     = 6 + 3 * 4 + 2 * 4;
    localparam int RANDOM_READS = 40;

    logic         core_clk_ifc;
    logic         peripheral_sresetn_core;
    logic         host_req;
    logic         host_wr;
    reg_addr_t    host_addr;
    reg_data_t    host_wdata;
    logic         host_ack;
    reg_data_t    host_rdata;
    logic         host_err;
    ing_cnt_arr_t ing_pkt_cnt;
    egr_cnt_arr_t egr_pkt_cnt;
    ing_mask_t    ing_fifo_ovf;
    ing_mask_t    ing_buf_ovf;
    egr_mask_t    egr_buf_drop;
    ing_mask_t    ing_ports_enable;
    egr_mask_t    egr_ports_enable;

    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    string       stim_lines[$];
    logic [31:0] lcg_state;

    router_stats_top router_stats_top_i (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .host_req                ( host_req                ),
        .host_wr                 ( host_wr                 ),
        .host_addr               ( host_addr               ),
        .host_wdata              ( host_wdata              ),
        .host_ack                ( host_ack                ),
        .host_rdata              ( host_rdata              ),
        .host_err                ( host_err                ),
        .ing_pkt_cnt             ( ing_pkt_cnt             ),
        .egr_pkt_cnt             ( egr_pkt_cnt             ),
        .ing_fifo_ovf            ( ing_fifo_ovf            ),
        .ing_buf_ovf             ( ing_buf_ovf             ),
        .egr_buf_drop            ( egr_buf_drop            ),
        .ing_ports_enable        ( ing_ports_enable        ),
        .egr_ports_enable        ( egr_ports_enable        )
    );

    initial core_clk_ifc = 1'b0;
    always #10 core_clk_ifc = ~core_clk_ifc;

    // Watchdog
    always @(posedge core_clk_ifc) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Register values after reset
    function automatic logic [31:0] reset_value(input int a);
        case (a)
            0:       return 32'h0100000A;
            1:       return 32'h00000404;
            2, 3:    return 32'h0000000F;
            default: return 32'h00000000;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    ////////////////////
    // Four-phase bus access
    task automatic bus_access(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                              output reg_data_t rdata, output logic err);
        @(negedge core_clk_ifc);
        host_req   = 1'b1;
        host_wr    = wr;
        host_addr  = addr;
        host_wdata = wdata;
        while (host_ack !== 1'b1) @(negedge core_clk_ifc);
        rdata    = host_rdata;
        err      = host_err;
        host_req = 1'b0;
        while (host_ack !== 1'b0) @(negedge core_clk_ifc);
    endtask

    task automatic drive_events(input string kind, input logic [3:0] mask);
        if (kind == "F") ing_fifo_ovf = mask;
        else if (kind == "B") ing_buf_ovf = mask;
        else egr_buf_drop = mask;
    endtask

    // One high cycle then one low cycle per pulse
    task automatic pulse_events(input string kind, input logic [3:0] mask, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge core_clk_ifc);
            drive_events(kind, mask);
            @(negedge core_clk_ifc);
            drive_events(kind, 4'h0);
        end
    endtask

    task automatic load_stim(output bit ok);
        int    fd;
        int    n;
        string line;
        ok = 1'b0;
        fd = $fopen("verification/router_stats_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Skip blank and comment lines
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    stim_lines.push_back(line);
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    task automatic run_stim_line(input string line);
        string       cmd;
        string       sel;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        reg_data_t   rdata;
        logic        err;
        int          n;
        n = $sscanf(line, "%s", cmd);
        if (cmd == "W" || cmd == "R") begin
            n = $sscanf(line, "%s %h %h %h", cmd, f1, f2, f3);
        end else begin
            n = $sscanf(line, "%s %s %h %h", cmd, sel, f1, f2);
        end
        if (n != 4) begin
            errors++;
            $display("Stimulus line has missing fields: %s", line);
        end else if (cmd == "W") begin
            bus_access(1'b1, reg_addr_t'(f1), f2, rdata, err);
            check_value($sformatf("write err @%02h", f1), f3, 32'(err));
            // Out-of-range writes return zero data as well
            if (f3 == 32'd1) begin
                check_value($sformatf("write data @%02h", f1), 32'd0, rdata);
            end
            if (f1 == 32'd2 && f3 == 32'd0) begin
                check_value("ing_ports_enable", 32'(f2[3:0]), 32'(ing_ports_enable));
            end
            if (f1 == 32'd3 && f3 == 32'd0) begin
                check_value("egr_ports_enable", 32'(f2[3:0]), 32'(egr_ports_enable));
            end
        end else if (cmd == "R") begin
            bus_access(1'b0, reg_addr_t'(f1), '0, rdata, err);
            check_value($sformatf("read data @%02h", f1), f2, rdata);
            check_value($sformatf("read err @%02h", f1), f3, 32'(err));
        end else if (cmd == "P") begin
            @(negedge core_clk_ifc);
            if (sel == "I") ing_pkt_cnt[f1[1:0]] = f2;
            else egr_pkt_cnt[f1[1:0]] = f2;
        end else if (cmd == "E") begin
            pulse_events(sel, f1[3:0], int'(f2));
        end else begin
            errors++;
            $display("Unknown command in stimulus file: %s", line);
        end
    endtask

    ////////////////////
    // Main sequence
    initial begin
        bit          stim_ok;
        reg_data_t   rdata;
        logic        err;
        int          a;
        peripheral_sresetn_core = 1'b0;
        host_req     = 1'b0;
        host_wr      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        ing_pkt_cnt  = '0;
        egr_pkt_cnt  = '0;
        ing_fifo_ovf = '0;
        ing_buf_ovf  = '0;
        egr_buf_drop = '0;
        load_stim(stim_ok);
        if (!stim_ok) begin
            errors++;
            $display("Stimulus file verification/router_stats_stim.txt could not be opened");
        end else begin
            cycle_limit = 40 * (stim_lines.size() + NUM_REGS + RANDOM_READS) + 200;
            repeat (8) @(negedge core_clk_ifc);
            peripheral_sresetn_core = 1'b1;
            @(negedge core_clk_ifc);
            check_value("reset ing_ports_enable", 32'hF, 32'(ing_ports_enable));
            check_value("reset egr_ports_enable", 32'hF, 32'(egr_ports_enable));
            check_value("reset host_ack", 32'd0, 32'(host_ack));
            check_value("reset host_err", 32'd0, 32'(host_err));
            check_value("reset host_rdata", 32'd0, host_rdata);
            for (int r = 0; r < NUM_REGS; r++) begin
                bus_access(1'b0, reg_addr_t'(r), '0, rdata, err);
                check_value($sformatf("reset read @%02h", r), reset_value(r), rdata);
                check_value($sformatf("reset err @%02h", r), 32'd0, 32'(err));
            end
            foreach (stim_lines[i]) begin
                run_stim_line(stim_lines[i]);
            end
            lcg_state = 32'hfa728d5f;
            for (int i = 0; i < RANDOM_READS; i++) begin
                lcg_state = lcg_next(lcg_state);
                a = int'(lcg_state[20:16]);
                bus_access(1'b0, reg_addr_t'(a), '0, rdata, err);
                if (a == 0 || a == 1) begin
                    check_value($sformatf("random read @%02h", a), reset_value(a), rdata);
                end
                if (a >= NUM_REGS) begin
                    check_value($sformatf("random read @%02h", a), 32'd0, rdata);
                    check_value($sformatf("random err @%02h", a), 32'd1, 32'(err));
                end else begin
                    check_value($sformatf("random err @%02h", a), 32'd0, 32'(err));
                end
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/router_stats_assert.sv
////////////////////
// Handshake and reset assertions for the register host
////////////////////

`timescale 1ns/1ps
`default_nettype none

module router_stats_assert
    import router_port_pkg::*;
(
    input logic      core_clk_ifc,
    input logic      peripheral_sresetn_core,
    input logic      host_req,
    input logic      host_ack,
    input logic      host_err,
    input ing_mask_t ing_ports_enable,
    input egr_mask_t egr_ports_enable
);

    ack_rise_with_req: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) $rose(host_ack) |-> $past(host_req))
        else $error("host_ack rose while host_req was low");

    ack_fall_after_req: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) $fell(host_ack) |-> !$past(host_req))
        else $error("host_ack fell while host_req was still high");

    err_with_ack: assert property (@(posedge core_clk_ifc)
        disable iff (!peripheral_sresetn_core) host_err |-> host_ack)
        else $error("host_err high without host_ack");

    // Enables come out of reset all ones
    enables_after_reset: assert property (@(posedge core_clk_ifc)
        $rose(peripheral_sresetn_core) |-> (ing_ports_enable == '1 && egr_ports_enable == '1))
        else $error("port enables not all ones after reset");

endmodule

bind router_reg_host router_stats_assert router_stats_assert_i (
    .core_clk_ifc            ( core_clk_ifc            ),
    .peripheral_sresetn_core ( peripheral_sresetn_core ),
    .host_req                ( host_req                ),
    .host_ack                ( host_ack                ),
    .host_err                ( host_err                ),
    .ing_ports_enable        ( ing_ports_enable        ),
    .egr_ports_enable        ( egr_ports_enable        )
);

`default_nettype wire

// File: logic/router_stats_top.sv
////////////////////
// Router statistics and control register block
////////////////////

`timescale 1ns/1ps
`default_nettype none

module router_stats_top
    import router_regmap_pkg::*, router_port_pkg::*;
(
    input  logic         core_clk_ifc,
    input  logic         peripheral_sresetn_core,
    input  logic         host_req,
    input  logic         host_wr,
    input  reg_addr_t    host_addr,
    input  reg_data_t    host_wdata,
    output logic         host_ack,
    output reg_data_t    host_rdata,
    output logic         host_err,
    input  ing_cnt_arr_t ing_pkt_cnt,
    input  egr_cnt_arr_t egr_pkt_cnt,
    input  ing_mask_t    ing_fifo_ovf,
    input  ing_mask_t    ing_buf_ovf,
    input  egr_mask_t    egr_buf_drop,
    output ing_mask_t    ing_ports_enable,
    output egr_mask_t    egr_ports_enable
);

    // Counter control from the host
    ing_mask_t ing_sample_con;
    egr_mask_t egr_sample_con;

    // Snapshots back to the host
    ing_cnt_arr_t ing_snap_pkt;
    ing_cnt_arr_t ing_snap_fifo_ovf;
    ing_cnt_arr_t ing_snap_buf_ovf;
    egr_cnt_arr_t egr_snap_pkt;
    egr_cnt_arr_t egr_snap_drop;

    router_reg_host router_reg_host_i (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .host_req                ( host_req                ),
        .host_wr                 ( host_wr                 ),
        .host_addr               ( host_addr               ),
        .host_wdata              ( host_wdata              ),
        .host_ack                ( host_ack                ),
        .host_rdata              ( host_rdata              ),
        .host_err                ( host_err                ),
        .ing_snap_pkt            ( ing_snap_pkt            ),
        .ing_snap_fifo_ovf       ( ing_snap_fifo_ovf       ),
        .ing_snap_buf_ovf        ( ing_snap_buf_ovf        ),
        .egr_snap_pkt            ( egr_snap_pkt            ),
        .egr_snap_drop           ( egr_snap_drop           ),
        .ing_sample_con          ( ing_sample_con          ),
        .egr_sample_con          ( egr_sample_con          ),
        .ing_ports_enable        ( ing_ports_enable        ),
        .egr_ports_enable        ( egr_ports_enable        )
    );

    ing_port_stats ing_port_stats_i (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .ing_sample_con          ( ing_sample_con          ),
        .ing_pkt_cnt             ( ing_pkt_cnt             ),
        .ing_fifo_ovf            ( ing_fifo_ovf            ),
        .ing_buf_ovf             ( ing_buf_ovf             ),
        .ing_snap_pkt            ( ing_snap_pkt            ),
        .ing_snap_fifo_ovf       ( ing_snap_fifo_ovf       ),
        .ing_snap_buf_ovf        ( ing_snap_buf_ovf        )
    );

    egr_port_stats egr_port_stats_i (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .egr_sample_con          ( egr_sample_con          ),
        .egr_pkt_cnt             ( egr_pkt_cnt             ),
        .egr_buf_drop            ( egr_buf_drop            ),
        .egr_snap_pkt            ( egr_snap_pkt            ),
        .egr_snap_drop           ( egr_snap_drop           )
    );

endmodule

`default_nettype wire

// File: logic/router_reg_host.sv
////////////////////
// Register host for the router statistics block
// Req/ack handshake, control registers and read decode
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "router_stats_macros.svh"

module router_reg_host
    import router_regmap_pkg::*, router_port_pkg::*;
(
    input  logic         core_clk_ifc,
    input  logic         peripheral_sresetn_core,
    input  logic         host_req,
    input  logic         host_wr,
    input  reg_addr_t    host_addr,
    input  reg_data_t    host_wdata,
    output logic         host_ack,
    output reg_data_t    host_rdata,
    output logic         host_err,
    input  ing_cnt_arr_t ing_snap_pkt,
    input  ing_cnt_arr_t ing_snap_fifo_ovf,
    input  ing_cnt_arr_t ing_snap_buf_ovf,
    input  egr_cnt_arr_t egr_snap_pkt,
    input  egr_cnt_arr_t egr_snap_drop,
    output ing_mask_t    ing_sample_con,
    output egr_mask_t    egr_sample_con,
    output ing_mask_t    ing_ports_enable,
    output egr_mask_t    egr_ports_enable
);

    localparam reg_data_t ID_WORD = {`ROUTER_MODULE_VERSION, `ROUTER_MODULE_ID};
    localparam reg_data_t PARAMS_WORD = {16'h0000,
                                         8'(`ROUTER_NUM_EGR_PORTS),
                                         8'(`ROUTER_NUM_ING_PORTS)};

    host_state_e state;
    logic        req_q;
    reg_addr_t   addr_q;
    reg_data_t   rd_data;
    logic        rd_err;

    // Address is captured once per transaction
    always_ff @(posedge core_clk_ifc) begin
        if (state == IDLE && req_q) begin
            addr_q <= host_addr;
        end
    end

    ////////////////////
    // Read decode
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        if (addr_q >= REG_TOTAL) begin
            rd_err = 1'b1;
        end else begin
            case (addr_q)
                REG_ID:          rd_data = ID_WORD;
                REG_PARAMS:      rd_data = PARAMS_WORD;
                REG_ING_EN_CON:  rd_data = reg_data_t'(ing_ports_enable);
                REG_EGR_EN_CON:  rd_data = reg_data_t'(egr_ports_enable);
                REG_ING_CNT_CON: rd_data = reg_data_t'(ing_sample_con);
                REG_EGR_CNT_CON: rd_data = reg_data_t'(egr_sample_con);
                default:         rd_data = '0;
            endcase
            // Snapshot words, packet count first in each port's group
            for (int p = 0; p < `ROUTER_NUM_ING_PORTS; p++) begin
                if (int'(addr_q) == REG_ING_SNAP_BASE + ING_SNAPS_PER_PORT * p) begin
                    rd_data = reg_data_t'(ing_snap_pkt[p]);
                end
                if (int'(addr_q) == REG_ING_SNAP_BASE + ING_SNAPS_PER_PORT * p + 1) begin
                    rd_data = reg_data_t'(ing_snap_fifo_ovf[p]);
                end
                if (int'(addr_q) == REG_ING_SNAP_BASE + ING_SNAPS_PER_PORT * p + 2) begin
                    rd_data = reg_data_t'(ing_snap_buf_ovf[p]);
                end
            end
            for (int p = 0; p < `ROUTER_NUM_EGR_PORTS; p++) begin
                if (int'(addr_q) == REG_EGR_SNAP_BASE + EGR_SNAPS_PER_PORT * p) begin
                    rd_data = reg_data_t'(egr_snap_pkt[p]);
                end
                if (int'(addr_q) == REG_EGR_SNAP_BASE + EGR_SNAPS_PER_PORT * p + 1) begin
                    rd_data = reg_data_t'(egr_snap_drop[p]);
                end
            end
        end
    end

    ////////////////////
    // Handshake FSM and control registers
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            state            <= IDLE;
            req_q            <= 1'b0;
            host_ack         <= 1'b0;
            host_err         <= 1'b0;
            host_rdata       <= '0;
            ing_ports_enable <= '1;
            egr_ports_enable <= '1;
            ing_sample_con   <= '0;
            egr_sample_con   <= '0;
        end else begin
            req_q <= host_req;
            case (state)
                IDLE: begin
                    if (req_q) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    host_rdata <= rd_data;
                    host_err   <= rd_err;
                    host_ack   <= 1'b1;
                    // Writes to read-only words fall through silently
                    if (host_wr && !rd_err) begin
                        case (addr_q)
                            REG_ING_EN_CON:
                                ing_ports_enable <= host_wdata[`ROUTER_NUM_ING_PORTS-1:0];
                            REG_EGR_EN_CON:
                                egr_ports_enable <= host_wdata[`ROUTER_NUM_EGR_PORTS-1:0];
                            REG_ING_CNT_CON:
                                ing_sample_con <= host_wdata[`ROUTER_NUM_ING_PORTS-1:0];
                            REG_EGR_CNT_CON:
                                egr_sample_con <= host_wdata[`ROUTER_NUM_EGR_PORTS-1:0];
                            default: begin
                            end
                        endcase
                    end
                    state <= RESPOND;
                end
                RESPOND: begin
                    // Hold the response until the host lets go
                    if (!req_q) begin
                        host_ack <= 1'b0;
                        host_err <= 1'b0;
                        state    <= RELEASE;
                    end
                end
                RELEASE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/egr_port_stats.sv
////////////////////
// Egress statistics
// Counts buffer-full drops, snapshots them per port
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "router_stats_macros.svh"

module egr_port_stats
    import router_port_pkg::*;
(
    input  logic         core_clk_ifc,
    input  logic         peripheral_sresetn_core,
    input  egr_mask_t    egr_sample_con,
    input  egr_cnt_arr_t egr_pkt_cnt,
    input  egr_mask_t    egr_buf_drop,
    output egr_cnt_arr_t egr_snap_pkt,
    output egr_cnt_arr_t egr_snap_drop
);

    egr_mask_t sample_d;
    egr_mask_t drop_d;

    egr_mask_t sample_rise;
    egr_mask_t drop_rise;

    // Drop events seen since the last snapshot
    egr_cnt_arr_t drop_cnt;

    assign sample_rise = egr_sample_con & ~sample_d;
    assign drop_rise   = egr_buf_drop & ~drop_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_d <= '0;
            drop_d   <= '0;
        end else begin
            sample_d <= egr_sample_con;
            drop_d   <= egr_buf_drop;
        end
    end

    ////////////////////
    // Counters and snapshots
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            drop_cnt      <= '0;
            egr_snap_pkt  <= '0;
            egr_snap_drop <= '0;
        end else begin
            for (int p = 0; p < `ROUTER_NUM_EGR_PORTS; p++) begin
                drop_cnt[p] <= event_cnt_next(drop_cnt[p], drop_rise[p], sample_rise[p]);
                if (sample_rise[p]) begin
                    egr_snap_pkt[p]  <= egr_pkt_cnt[p];
                    egr_snap_drop[p] <= drop_cnt[p];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/ing_port_stats.sv
////////////////////
// Ingress statistics
// Counts FIFO and buffer overflow events, snapshots them per port
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "router_stats_macros.svh"

module ing_port_stats
    import router_port_pkg::*;
(
    input  logic         core_clk_ifc,
    input  logic         peripheral_sresetn_core,
    input  ing_mask_t    ing_sample_con,
    input  ing_cnt_arr_t ing_pkt_cnt,
    input  ing_mask_t    ing_fifo_ovf,
    input  ing_mask_t    ing_buf_ovf,
    output ing_cnt_arr_t ing_snap_pkt,
    output ing_cnt_arr_t ing_snap_fifo_ovf,
    output ing_cnt_arr_t ing_snap_buf_ovf
);

    // Previous-cycle copies for edge detection
    ing_mask_t sample_d;
    ing_mask_t fifo_ovf_d;
    ing_mask_t buf_ovf_d;

    ing_mask_t sample_rise;
    ing_mask_t fifo_ovf_rise;
    ing_mask_t buf_ovf_rise;

    // Event counts of the running interval
    ing_cnt_arr_t fifo_ovf_cnt;
    ing_cnt_arr_t buf_ovf_cnt;

    assign sample_rise   = ing_sample_con & ~sample_d;
    assign fifo_ovf_rise = ing_fifo_ovf & ~fifo_ovf_d;
    assign buf_ovf_rise  = ing_buf_ovf & ~buf_ovf_d;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_d   <= '0;
            fifo_ovf_d <= '0;
            buf_ovf_d  <= '0;
        end else begin
            sample_d   <= ing_sample_con;
            fifo_ovf_d <= ing_fifo_ovf;
            buf_ovf_d  <= ing_buf_ovf;
        end
    end

    ////////////////////
    // Counters and snapshots
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            fifo_ovf_cnt      <= '0;
            buf_ovf_cnt       <= '0;
            ing_snap_pkt      <= '0;
            ing_snap_fifo_ovf <= '0;
            ing_snap_buf_ovf  <= '0;
        end else begin
            for (int p = 0; p < `ROUTER_NUM_ING_PORTS; p++) begin
                fifo_ovf_cnt[p] <= event_cnt_next(fifo_ovf_cnt[p], fifo_ovf_rise[p],
                                                  sample_rise[p]);
                buf_ovf_cnt[p]  <= event_cnt_next(buf_ovf_cnt[p], buf_ovf_rise[p],
                                                  sample_rise[p]);
                // Snapshot takes the counts from before this cycle's edges
                if (sample_rise[p]) begin
                    ing_snap_pkt[p]      <= ing_pkt_cnt[p];
                    ing_snap_fifo_ovf[p] <= fifo_ovf_cnt[p];
                    ing_snap_buf_ovf[p]  <= buf_ovf_cnt[p];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/router_port_pkg.sv
////////////////////
// Per-port masks and counter types
////////////////////

`default_nettype none

`include "router_stats_macros.svh"

package router_port_pkg;

    typedef logic [`ROUTER_NUM_ING_PORTS-1:0] ing_mask_t;
    typedef logic [`ROUTER_NUM_EGR_PORTS-1:0] egr_mask_t;
    typedef logic [`ROUTER_CNT_WIDTH-1:0]     cnt_t;

    // One counter per port, port 0 in the low word
    typedef cnt_t [`ROUTER_NUM_ING_PORTS-1:0] ing_cnt_arr_t;
    typedef cnt_t [`ROUTER_NUM_EGR_PORTS-1:0] egr_cnt_arr_t;

    // Next value of an event counter; a snapshot restarts the interval,
    // an edge in that same cycle lands in the new interval
    function automatic cnt_t event_cnt_next(input cnt_t cnt, input logic rise, input logic snap);
        cnt_t base;
        base = snap ? '0 : cnt;
        return rise ? base + 1'b1 : base;
    endfunction

endpackage

`default_nettype wire

// File: logic/router_regmap_pkg.sv
////////////////////
// Router register map, bus word types and host FSM states
////////////////////

`default_nettype none

`include "router_stats_macros.svh"

package router_regmap_pkg;

    typedef logic [`ROUTER_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`ROUTER_DATA_WIDTH-1:0] reg_data_t;

    // Snapshot words per port
    localparam int ING_SNAPS_PER_PORT = 3;
    localparam int EGR_SNAPS_PER_PORT = 2;

    // Word addresses of the map
    typedef enum reg_addr_t {
        REG_ID            = 8'd0,
        REG_PARAMS        = 8'd1,
        REG_ING_EN_CON    = 8'd2,
        REG_EGR_EN_CON    = 8'd3,
        REG_ING_CNT_CON   = 8'd4,
        REG_EGR_CNT_CON   = 8'd5,
        REG_ING_SNAP_BASE = 8'd6,
        REG_EGR_SNAP_BASE = reg_addr_t'(6 + ING_SNAPS_PER_PORT * `ROUTER_NUM_ING_PORTS),
        REG_TOTAL         = reg_addr_t'(6 + ING_SNAPS_PER_PORT * `ROUTER_NUM_ING_PORTS
                                          + EGR_SNAPS_PER_PORT * `ROUTER_NUM_EGR_PORTS)
    } reg_addr_e;

    // Four-phase handshake FSM
    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        RESPOND,
        RELEASE
    } host_state_e;

endpackage

`default_nettype wire

// File: include/router_stats_macros.svh
////////////////////
// Router statistics block constants
// Port counts, datapath widths and identity
////////////////////

`ifndef ROUTER_STATS_MACROS_SVH
`define ROUTER_STATS_MACROS_SVH

// Physical ports per direction
`define ROUTER_NUM_ING_PORTS 4
`define ROUTER_NUM_EGR_PORTS 4

// Counter and register bus widths
`define ROUTER_CNT_WIDTH 32
`define ROUTER_DATA_WIDTH 32
`define ROUTER_ADDR_WIDTH 8

// Identity word halves, version 1.0 sits in the upper half
`define ROUTER_MODULE_ID 16'd10
`define ROUTER_MODULE_VERSION 16'h0100

`endif
